/* source/nco_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths, latency, table amplitude and enums for the NCO
// referenced by scoped names from every design file
////////////////////////////////////////////////////////////

package nco_pkg;

  // sample counter and phase width
  localparam int count_w = 24;

  // coefficient is sign-magnitude: msb sign, low 24 bits magnitude
  localparam int coef_w = 25;

  // quarter-wave table addressing
  localparam int lut_aw = 8;                  // 256 entries per quadrant
  localparam int lut_depth = 2**lut_aw + 1;   // extra entry at pi/2

  // interpolation fraction, below the quadrant and address fields
  localparam int frac_w = count_w - 2 - lut_aw;

  // signed sample width and table full scale
  localparam int precision = 16;
  localparam int lut_amp = 32767;

  // counter at interpolator input to sample at output
  localparam int nco_latency = 9;

  // top two phase bits
  typedef enum logic [1:0] {
    quad_0,
    quad_1,
    quad_2,
    quad_3
  } quad_e;

  // four-phase req/ack on the config port
  typedef enum logic [1:0] {
    cfg_idle,     // waiting for req
    cfg_ack,      // ack high until req drops
    cfg_release   // one cycle gap before next accept
  } cfg_state_e;

endpackage

/* source/sincos_lut_if.sv */
////////////////////////////////////////////////////////////
// table access between interpolator and quarter-wave table
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface sincos_lut_if (
  input logic clk
);

  logic [nco_pkg::lut_aw-1:0]           ptr;       // table address
  logic signed [nco_pkg::precision-1:0] curr_sin;  // entry at ptr
  logic signed [nco_pkg::precision-1:0] curr_cos;
  logic signed [nco_pkg::precision-1:0] next_sin;  // entry at ptr+1
  logic signed [nco_pkg::precision-1:0] next_cos;

  // interpolator side, data comes back one clock after ptr
  modport master (input clk, output ptr,
                  input curr_sin, curr_cos, next_sin, next_cos);

  // table side
  modport lut_table (input clk, input ptr,
                     output curr_sin, curr_cos, next_sin, next_cos);

endinterface

/* source/sincos_lut.sv */
////////////////////////////////////////////////////////////
// quarter-wave sine/cosine table with one cycle registered read
// attached to the interpolator through sincos_lut_if
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sincos_lut (
  input logic             clk,
  input logic             resetn,
  sincos_lut_if.lut_table lut
);

  // one sine array also serves cosine as cos(k) = sin(256-k)
  logic signed [nco_pkg::precision-1:0] sin_tab [0:nco_pkg::lut_depth-1];

  logic [nco_pkg::lut_aw:0] curr_a;      // one extra bit for entry 256
  logic [nco_pkg::lut_aw:0] next_a;
  logic [nco_pkg::lut_aw:0] cos_curr_a;
  logic [nco_pkg::lut_aw:0] cos_next_a;

  // fill at start-up with round to nearest
  initial begin
    real    ang;
    integer val;
    for (int k = 0; k < nco_pkg::lut_depth; k++) begin
      ang = 3.14159265358979323846 * k / (2.0 * (nco_pkg::lut_depth - 1));
      val = $rtoi(nco_pkg::lut_amp * $sin(ang) + 0.5);  // all entries >= 0
      sin_tab[k] = val[nco_pkg::precision-1:0];
    end
  end

  assign curr_a     = {1'b0, lut.ptr};
  assign next_a     = curr_a + 1'b1;          // reaches 256 at ptr 255
  assign cos_curr_a = {1'b1, {nco_pkg::lut_aw{1'b0}}} - curr_a;  // mirrored about pi/2
  assign cos_next_a = {1'b1, {nco_pkg::lut_aw{1'b0}}} - next_a;

  // registered read of current and next entries
  always_ff @(posedge clk) begin
    lut.curr_sin <= sin_tab[curr_a];
    lut.next_sin <= sin_tab[next_a];
    lut.curr_cos <= sin_tab[cos_curr_a];
    lut.next_cos <= sin_tab[cos_next_a];
  end

  // a known ptr from the interpolator must give known data a cycle later
  a_data_known: assert property (
    @(posedge lut.clk) disable iff (!resetn)
    !$isunknown(lut.ptr) |=>
      !$isunknown({lut.curr_sin, lut.curr_cos, lut.next_sin, lut.next_cos})
  ) else $error("sincos_lut: unknown read data");

endmodule

/* source/phase_counter.sv */
////////////////////////////////////////////////////////////
// coefficient register behind a four-phase req/ack port
// plus the run-gated sample counter feeding the interpolator
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phase_counter (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       run,         // advance counter
  input  logic                       cfg_req,     // host request
  input  logic [nco_pkg::coef_w-1:0] cfg_coef,    // held with req
  output logic                       cfg_ack,
  output logic [nco_pkg::count_w-1:0] cntr,       // sample index
  output logic [nco_pkg::coef_w-1:0] coef,        // sign-magnitude
  output logic                       cntr_valid   // run, registered
);

  nco_pkg::cfg_state_e cfg_state;
  logic                cfg_accept;   // req seen in idle

  assign cfg_accept = (cfg_state == nco_pkg::cfg_idle) && cfg_req;
  assign cfg_ack    = (cfg_state == nco_pkg::cfg_ack);  // straight from state reg

  // handshake FSM, latches coef on accept
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cfg_state <= nco_pkg::cfg_idle;
      coef      <= '0;
    end else begin
      case (cfg_state)
        nco_pkg::cfg_idle: begin
          if (cfg_req) begin
            coef      <= cfg_coef;
            cfg_state <= nco_pkg::cfg_ack;
          end
        end
        nco_pkg::cfg_ack: begin
          if (!cfg_req) begin
            cfg_state <= nco_pkg::cfg_release;  // ack falls here
          end
        end
        nco_pkg::cfg_release: begin
          cfg_state <= nco_pkg::cfg_idle;       // host may re-raise req now
        end
        default: begin
          cfg_state <= nco_pkg::cfg_idle;
        end
      endcase
    end
  end

  // counter moves past a value only once it went out as valid,
  // so a run-low pause resumes at the next unsent index
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cntr       <= '0;
      cntr_valid <= 1'b0;
    end else begin
      cntr_valid <= run;
      if (cfg_accept) begin
        cntr <= '0;                    // restart on new coefficient
      end else if (cntr_valid) begin
        cntr <= cntr + 1'b1;
      end
    end
  end

  // ack only ever follows a request
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!resetn)
    $rose(cfg_ack) |-> $past(cfg_req)
  ) else $error("phase_counter: cfg_ack rose without cfg_req");

  // coefficient only moves on an accepted handshake
  a_coef_on_accept: assert property (
    @(posedge clk) disable iff (!resetn)
    !$stable(coef) |-> $past(cfg_accept)
  ) else $error("phase_counter: coef changed outside handshake");

endmodule

/* source/nco_interp.sv */
////////////////////////////////////////////////////////////
// phase product, quadrant map and linear interpolation, 9 stages
// drives the table through the master modport, outputs {Q,I}
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module nco_interp (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic [nco_pkg::count_w-1:0]       cntr,
  input  logic [nco_pkg::coef_w-1:0]        coef,
  input  logic                              cntr_valid,
  sincos_lut_if.master                      lut,
  output logic signed [2*nco_pkg::precision-1:0] sincos,   // {Q,I}
  output logic                              sincos_valid
);

  localparam int pw = nco_pkg::precision;
  localparam int mw = nco_pkg::precision + nco_pkg::frac_w + 1;  // delta x frac

  // product stages
  logic [nco_pkg::coef_w-2:0]  mag_q;     // coefficient magnitude
  logic [nco_pkg::count_w-1:0] cntr_q;
  logic [nco_pkg::count_w-1:0] phase_q;   // low bits of mag*cntr

  // side delay lines
  nco_pkg::quad_e              quad_q [0:1];
  logic [nco_pkg::frac_w-1:0]  frac_q [0:3];
  logic                        sign_q [0:nco_pkg::nco_latency-2];
  logic                        vld_q  [0:nco_pkg::nco_latency-1];

  // table output register
  logic signed [pw-1:0] q0_curr_sin, q0_curr_cos;
  logic signed [pw-1:0] q0_next_sin, q0_next_cos;

  // after quadrant map
  logic signed [pw-1:0] map_curr_sin, map_curr_cos;
  logic signed [pw-1:0] map_next_sin, map_next_cos;

  // delta, multiply and aligned curr
  logic signed [pw-1:0] dsin_q, dcos_q;
  logic signed [mw-1:0] msin_a, mcos_a;
  logic signed [mw-1:0] msin_b, mcos_b;
  logic signed [pw-1:0] curr_sin_q [0:2];
  logic signed [pw-1:0] curr_cos_q [0:2];

  logic signed [pw-1:0] sin_sum, cos_sum, sin_out;

  // stage 1,2: product, kept reset so ptr is never unknown
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mag_q   <= '0;
      cntr_q  <= '0;
      phase_q <= '0;
    end else begin
      mag_q   <= coef[nco_pkg::coef_w-2:0];
      cntr_q  <= cntr;
      phase_q <= mag_q * cntr_q;   // wraps to count_w bits
    end
  end

  // field split: quadrant | table address | fraction
  assign lut.ptr = phase_q[nco_pkg::count_w-3 -: nco_pkg::lut_aw];

  // stage 3,4: table read then table output register
  always_ff @(posedge clk) begin
    quad_q[0]   <= nco_pkg::quad_e'(phase_q[nco_pkg::count_w-1 -: 2]);
    quad_q[1]   <= quad_q[0];
    q0_curr_sin <= lut.curr_sin;
    q0_curr_cos <= lut.curr_cos;
    q0_next_sin <= lut.next_sin;
    q0_next_cos <= lut.next_cos;
  end

  // stage 5: rotate the first-quadrant pair by quad
  always_ff @(posedge clk) begin
    case (quad_q[1])
      nco_pkg::quad_1: begin
        map_curr_sin <= q0_curr_cos;
        map_curr_cos <= -q0_curr_sin;
        map_next_sin <= q0_next_cos;
        map_next_cos <= -q0_next_sin;
      end
      nco_pkg::quad_2: begin       // both negated
        map_curr_sin <= -q0_curr_sin;
        map_curr_cos <= -q0_curr_cos;
        map_next_sin <= -q0_next_sin;
        map_next_cos <= -q0_next_cos;
      end
      nco_pkg::quad_3: begin
        map_curr_sin <= -q0_curr_cos;
        map_curr_cos <= q0_curr_sin;
        map_next_sin <= -q0_next_cos;
        map_next_cos <= q0_next_sin;
      end
      default: begin               // quad_0 passes through
        map_curr_sin <= q0_curr_sin;
        map_curr_cos <= q0_curr_cos;
        map_next_sin <= q0_next_sin;
        map_next_cos <= q0_next_cos;
      end
    endcase
  end

  // stage 6..8: slope, then two-cycle multiply by fraction
  always_ff @(posedge clk) begin
    frac_q[0] <= phase_q[nco_pkg::frac_w-1:0];
    for (int i = 1; i < 4; i++) begin
      frac_q[i] <= frac_q[i-1];
    end
    dsin_q <= map_next_sin - map_curr_sin;   // small, stays within one step
    dcos_q <= map_next_cos - map_curr_cos;
    msin_a <= dsin_q * $signed({1'b0, frac_q[3]});
    mcos_a <= dcos_q * $signed({1'b0, frac_q[3]});
    msin_b <= msin_a;
    mcos_b <= mcos_a;
    curr_sin_q[0] <= map_curr_sin;
    curr_cos_q[0] <= map_curr_cos;
    for (int i = 1; i < 3; i++) begin
      curr_sin_q[i] <= curr_sin_q[i-1];
      curr_cos_q[i] <= curr_cos_q[i-1];
    end
  end

  // floor shift by frac_w, then add the base entry
  assign sin_sum = curr_sin_q[2] + msin_b[nco_pkg::frac_w +: pw];
  assign cos_sum = curr_cos_q[2] + mcos_b[nco_pkg::frac_w +: pw];
  assign sin_out = sign_q[nco_pkg::nco_latency-2] ? -sin_sum : sin_sum;  // negative coef

  // sign and valid ride along, output register at stage 9
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < nco_pkg::nco_latency - 1; i++) begin
        sign_q[i] <= 1'b0;
      end
      for (int i = 0; i < nco_pkg::nco_latency; i++) begin
        vld_q[i] <= 1'b0;
      end
      sincos <= '0;
    end else begin
      sign_q[0] <= coef[nco_pkg::coef_w-1];
      vld_q[0]  <= cntr_valid;
      for (int i = 1; i < nco_pkg::nco_latency - 1; i++) begin
        sign_q[i] <= sign_q[i-1];
      end
      for (int i = 1; i < nco_pkg::nco_latency; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
      sincos <= vld_q[nco_pkg::nco_latency-2] ? {sin_out, cos_sum} : '0;
    end
  end

  assign sincos_valid = vld_q[nco_pkg::nco_latency-1];

  // idle output is zero
  a_idle_zero: assert property (
    @(posedge clk) disable iff (!resetn)
    !sincos_valid |-> (sincos == '0)
  ) else $error("nco_interp: sincos nonzero while not valid");

endmodule

/* source/nco_top.sv */
////////////////////////////////////////////////////////////
// NCO top: config port in, {Q,I} sample stream out
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module nco_top (
  input  logic                                   clk,
  input  logic                                   resetn,
  input  logic                                   run,
  input  logic                                   cfg_req,
  input  logic [nco_pkg::coef_w-1:0]             cfg_coef,
  output logic                                   cfg_ack,
  output logic signed [2*nco_pkg::precision-1:0] sincos,
  output logic                                   sincos_valid
);

  logic [nco_pkg::count_w-1:0] cntr;
  logic [nco_pkg::coef_w-1:0]  coef;
  logic                        cntr_valid;

  sincos_lut_if u_lut_if (.clk(clk));   // interp <-> table

  phase_counter u_phase_counter (
    .clk        (clk),
    .resetn     (resetn),
    .run        (run),
    .cfg_req    (cfg_req),
    .cfg_coef   (cfg_coef),
    .cfg_ack    (cfg_ack),
    .cntr       (cntr),
    .coef       (coef),
    .cntr_valid (cntr_valid)
  );

  nco_interp u_nco_interp (
    .clk          (clk),
    .resetn       (resetn),
    .cntr         (cntr),
    .coef         (coef),
    .cntr_valid   (cntr_valid),
    .lut          (u_lut_if.master),
    .sincos       (sincos),
    .sincos_valid (sincos_valid)
  );

  sincos_lut u_sincos_lut (
    .clk    (clk),
    .resetn (resetn),
    .lut    (u_lut_if.lut_table)
  );

endmodule

/* tests/nco_ref.svh */
////////////////////////////////////////////////////////////
// NCO reference model, included inside the testbench module
////////////////////////////////////////////////////////////

`ifndef NCO_REF_SVH
`define NCO_REF_SVH

// quarter-wave sine at table index k, rounded to nearest
function automatic int ref_tab_sin(input int k);
  real ang;
  ang = 3.14159265358979323846 * k / (2.0 * (1 << nco_pkg::lut_aw));
  return $rtoi(nco_pkg::lut_amp * $sin(ang) + 0.5);
endfunction

// low count_w bits of magnitude times counter
function automatic logic [nco_pkg::count_w-1:0] phase_of(
  input logic [nco_pkg::coef_w-1:0] coef, input int unsigned idx);
  logic [2*nco_pkg::count_w-1:0] prod;
  prod = coef[nco_pkg::coef_w-2:0] * idx[nco_pkg::count_w-1:0];
  return prod[nco_pkg::count_w-1:0];
endfunction

// linear step, floor division by 2^frac_w
function automatic int lin_interp(input int c, input int n, input int f);
  return c + (((n - c) * f) >>> nco_pkg::frac_w);
endfunction

// expected {Q,I} for a coefficient and sample index
function automatic logic [2*nco_pkg::precision-1:0] ref_sample(
  input logic [nco_pkg::coef_w-1:0] coef, input int unsigned idx);
  logic [nco_pkg::count_w-1:0] ph;
  int ptr, frac, cs, cc, ns, nc, s, c;
  ph   = phase_of(coef, idx);
  ptr  = ph[nco_pkg::count_w-3 -: nco_pkg::lut_aw];
  frac = ph[nco_pkg::frac_w-1:0];
  cs = ref_tab_sin(ptr);           // first quadrant pair
  cc = ref_tab_sin(256 - ptr);
  ns = ref_tab_sin(ptr + 1);
  nc = ref_tab_sin(255 - ptr);
  case (nco_pkg::quad_e'(ph[nco_pkg::count_w-1 -: 2]))
    nco_pkg::quad_1: begin s = lin_interp(cc, nc, frac);  c = lin_interp(-cs, -ns, frac); end
    nco_pkg::quad_2: begin s = lin_interp(-cs, -ns, frac); c = lin_interp(-cc, -nc, frac); end
    nco_pkg::quad_3: begin s = lin_interp(-cc, -nc, frac); c = lin_interp(cs, ns, frac);  end
    default:         begin s = lin_interp(cs, ns, frac);  c = lin_interp(cc, nc, frac);  end
  endcase
  if (coef[nco_pkg::coef_w-1]) s = -s;   // reversed rotation
  return {s[nco_pkg::precision-1:0], c[nco_pkg::precision-1:0]};
endfunction

`endif

/* tests/nco_tb.sv */
////////////////////////////////////////////////////////////
// directed testbench for nco_top against the nco_ref model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module nco_tb;

  logic                              clk;
  logic                              resetn;
  logic                              run;
  logic                              cfg_req;
  logic [nco_pkg::coef_w-1:0]        cfg_coef;
  logic                              cfg_ack;
  logic [2*nco_pkg::precision-1:0]   sincos;
  logic                              sincos_valid;

  logic [nco_pkg::coef_w-1:0] cur_coef;   // coefficient last loaded
  int unsigned                idx;        // own copy of the sample counter
  logic                       prev_req;

  `include "nco_ref.svh"

  nco_top u_nco_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // ack may only rise after req was seen high
  always @(negedge clk) begin
    if (resetn) begin
      assert (!(cfg_ack && !prev_req)) else fail_run("cfg_ack raised while cfg_req was low");
    end
    prev_req = cfg_req;
  end

  task automatic check_sample(input bit chk_tol);
    logic [2*nco_pkg::precision-1:0] exp, pos;
    real ang;
    int  si, co, gs, gc;
    exp = ref_sample(cur_coef, idx);
    assert (sincos == exp) else
      fail_run($sformatf("Mismatch at %0t: sample %0d got %h expected %h",
                         $time, idx, sincos, exp));
    if (cur_coef == '0) begin                  // no rotation at all
      assert (sincos == {16'sd0, 16'(nco_pkg::lut_amp)}) else
        fail_run($sformatf("Mismatch at %0t: zero coefficient gave %h", $time, sincos));
    end
    if (cur_coef[nco_pkg::coef_w-1]) begin     // mirror of the positive coefficient
      pos = ref_sample({1'b0, cur_coef[nco_pkg::coef_w-2:0]}, idx);
      assert (sincos[15:0] == pos[15:0] && sincos[31:16] == -pos[31:16]) else
        fail_run($sformatf("Mismatch at %0t: sample %0d not a mirrored rotation", $time, idx));
    end
    if (chk_tol) begin
      ang = 6.28318530717958647692 * phase_of(cur_coef, idx) / (2.0 ** nco_pkg::count_w);
      si  = $rtoi($floor(nco_pkg::lut_amp * $sin(ang) + 0.5));
      co  = $rtoi($floor(nco_pkg::lut_amp * $cos(ang) + 0.5));
      if (cur_coef[nco_pkg::coef_w-1]) si = -si;
      gs = $signed(sincos[31:16]);
      gc = $signed(sincos[15:0]);
      assert ((gs - si) <= 4 && (si - gs) <= 4 && (gc - co) <= 4 && (co - gc) <= 4) else
        fail_run($sformatf("Mismatch at %0t: sample %0d (%0d,%0d) far from (%0d,%0d)",
                           $time, idx, gs, gc, si, co));
    end
    idx++;
  endtask

  // full four-phase handshake while run is low
  task automatic load_coef(input logic [nco_pkg::coef_w-1:0] c);
    int n;
    @(posedge clk);
    cfg_coef <= c;
    cfg_req  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      if (++n > 20) fail_run("cfg_ack did not rise after cfg_req");
    end while (!cfg_ack);
    repeat (3) begin                 // ack holds while req is high
      @(negedge clk);
      assert (cfg_ack) else fail_run("cfg_ack dropped while cfg_req was high");
    end
    @(posedge clk);
    cfg_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      if (++n > 20) fail_run("cfg_ack did not fall after cfg_req dropped");
    end while (cfg_ack);
    cur_coef = c;
    idx      = 0;
  endtask

  // run for n valid samples, then stop and drain the pipeline
  task automatic run_and_check(input int n, input bit chk_lat, input bit chk_tol);
    int got, cyc, quiet;
    got = 0;
    cyc = 0;
    @(posedge clk);
    run <= 1'b1;
    while (got < n) begin
      @(negedge clk);
      cyc++;
      if (cyc > n + 100) fail_run("valid samples stopped arriving while run was high");
      if (sincos_valid) begin
        if (got == 0 && chk_lat) begin
          // cyc counts the drive edge's own half cycle too
          assert (cyc - 1 == nco_pkg::nco_latency + 1) else
            fail_run($sformatf("Mismatch at %0t: first valid after %0d cycles", $time, cyc - 1));
        end
        check_sample(chk_tol);
        got++;
      end
    end
    @(posedge clk);
    run <= 1'b0;
    quiet = 0;
    cyc   = 0;
    while (quiet < nco_pkg::nco_latency + 2) begin
      @(negedge clk);
      if (++cyc > 50) fail_run("pipeline did not drain after run dropped");
      if (sincos_valid) begin
        check_sample(chk_tol);
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  // load c with run left high, samples in flight finish on the old coefficient
  task automatic reload_while_running(input logic [nco_pkg::coef_w-1:0] c, input int n_old);
    int got, cyc, old_left;
    got      = 0;
    cyc      = 0;
    old_left = -1;                   // counts down once ack is seen
    @(posedge clk);
    run <= 1'b1;
    while (got < n_old) begin
      @(negedge clk);
      if (++cyc > n_old + 50) fail_run("valid samples stopped arriving while run was high");
      if (sincos_valid) begin
        check_sample(1'b1);
        got++;
      end
    end
    @(posedge clk);
    cfg_coef <= c;
    cfg_req  <= 1'b1;
    cyc = 0;
    while (old_left != 0) begin
      @(negedge clk);
      if (++cyc > 20) fail_run("cfg_ack did not rise after cfg_req while running");
      if (sincos_valid) begin
        check_sample(1'b1);
        if (old_left > 0) old_left--;
      end
      if (cfg_ack && cfg_req) begin  // accepted on the last edge
        old_left = nco_pkg::nco_latency - 1;
        @(posedge clk);
        cfg_req <= 1'b0;
      end
    end
    cur_coef = c;                    // counter restarted at the accept edge
    idx      = 0;
  endtask

  initial begin
    logic [nco_pkg::coef_w-1:0] rc;
    void'($urandom(80));
    resetn   = 1'b0;
    run      = 1'b0;
    cfg_req  = 1'b0;
    cfg_coef = '0;
    prev_req = 1'b0;
    cur_coef = '0;
    idx      = 0;

    repeat (16) begin               // reset state while held
      @(negedge clk);
      assert (!cfg_ack && !sincos_valid && sincos == '0) else
        fail_run("outputs not idle during reset");
    end
    @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    assert (!cfg_ack && !sincos_valid && sincos == '0) else
      fail_run("outputs not idle after reset");

    // zero coefficient gives constant (0, amp) at exact latency
    load_coef('0);
    run_and_check(20, 1'b1, 1'b0);

    // table-aligned phases over more than one turn with a pause
    load_coef(25'(1 << nco_pkg::frac_w));
    run_and_check(600, 1'b1, 1'b1);
    run_and_check(500, 1'b0, 1'b1);

    // sign bit set mirrors the sine
    load_coef({1'b1, 24'(1 << nco_pkg::frac_w)});
    run_and_check(1100, 1'b0, 1'b1);

    // random magnitudes with the last one negative
    for (int t = 0; t < 5; t++) begin
      rc = {(t == 4), 24'($urandom)};
      load_coef(rc);
      run_and_check(200, 1'b0, 1'b1);
    end

    // new coefficient mid-run restarts the counter after the drain
    reload_while_running({1'b0, 24'($urandom)}, 40);
    run_and_check(100, 1'b0, 1'b1);

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* src.f */
source/nco_pkg.sv
source/sincos_lut_if.sv
source/sincos_lut.sv
source/phase_counter.sv
source/nco_interp.sv
source/nco_top.sv
+incdir+tests
tests/nco_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the NCO testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  -f src.f \
  --top-module nco_tb \
  -Mdir obj_dir \
  -o nco_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out="$(./obj_dir/nco_sim 2>&1)"
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "TEST PASSED"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi
